//--- common/riscv_pkg.sv
package riscv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // --------------------
    // opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // alu functions
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [31:0] NOP_INST = 32'h00000013; // addi x0, x0, 0
    localparam logic [31:0] RESET_PC = 32'h00000000;

    // --------------------
    // memory map
    localparam logic [31:0] ADDR_CYCLE_CNT   = 32'h80000010;
    localparam logic [31:0] ADDR_INSTR_CNT   = 32'h80000014;
    localparam logic [31:0] ADDR_CNT_RESET   = 32'h80000018;
    localparam logic [31:0] ADDR_SWITCHES    = 32'h80000028;
    localparam logic [31:0] ADDR_LEDS        = 32'h80000030;
    localparam logic [31:0] ADDR_TONE_EN     = 32'h80000034;
    localparam logic [31:0] ADDR_TONE_PERIOD = 32'h80000038;

    localparam int TONE_PERIOD_W = 24;
    localparam logic [TONE_PERIOD_W-1:0] TONE_PERIOD_RESET = 24'h555;
    localparam int SWITCH_W = 8;
    localparam int LED_W    = 6;
    localparam int PMOD_W   = 8;

    // writeback source
    localparam logic [1:0] WB_PC4  = 2'd0;
    localparam logic [1:0] WB_ALU  = 2'd1;
    localparam logic [1:0] WB_MMIO = 2'd2;
    localparam logic [1:0] WB_IMM  = 2'd3;

    // --------------------
    // one instruction word, six views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } inst_u;

endpackage

//--- common/stage_if.sv
// fetch/decode to execute
interface fd_ex_if import riscv_pkg::*; ();
    logic            valid;
    inst_u           inst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;      // sign extended, format picked by opcode

    modport fd (output valid, inst, pc, rs1_data, rs2_data, imm);
    modport ex (input valid, inst, pc, rs1_data, rs2_data, imm);
endinterface

// execute to memory/writeback
interface ex_wb_if import riscv_pkg::*; ();
    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_we;
    logic [1:0]            wb_sel;
    logic [XLEN-1:0]       result;     // alu out, doubles as mmio address
    logic [XLEN-1:0]       store_data;
    logic                  is_load;
    logic                  is_store;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       imm;

    modport ex (output valid, rd, reg_we, wb_sel, result, store_data, is_load, is_store, pc, imm);
    modport wb (input valid, rd, reg_we, wb_sel, result, store_data, is_load, is_store, pc, imm);
endinterface

//--- fetch_decode/reg_file.sv
module reg_file import riscv_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] ra1,
    input  logic [REG_ADDR_W-1:0] ra2,
    output logic [XLEN-1:0]       rd1,
    output logic [XLEN-1:0]       rd2,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] wa,
    input  logic [XLEN-1:0]       wd
);

    logic [XLEN-1:0] regs [1:31]; // x0 not stored

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // write-through so a same-cycle write is seen by decode
    always_comb begin
        if (ra1 == '0)                rd1 = '0;
        else if (we && wa == ra1)     rd1 = wd;
        else                          rd1 = regs[ra1];

        if (ra2 == '0)                rd2 = '0;
        else if (we && wa == ra2)     rd2 = wd;
        else                          rd2 = regs[ra2];
    end

    a_wd_known: assert property (@(posedge clk) we |-> !$isunknown(wd));

endmodule

//--- fetch_decode/fetch_decode.sv
module fetch_decode import riscv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    output logic [XLEN-1:0]       imem_addr,
    input  logic [XLEN-1:0]       imem_data,
    input  logic                  redirect,
    input  logic [XLEN-1:0]       redirect_pc,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic                  wb_we,
    input  logic [XLEN-1:0]       wb_data,
    fd_ex_if.fd                   fd
);

    logic [XLEN-1:0] pc;          // address of the word now on imem_data
    logic            fetch_valid; // imem_data not yet meaningful right out of reset
    logic            kill;
    inst_u           inst;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    assign inst      = imem_data;
    assign imem_addr = redirect ? redirect_pc : pc + 32'd4;
    assign kill      = redirect || !fetch_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= RESET_PC - 32'd4; // first next-pc lands on RESET_PC
            fetch_valid <= 1'b0;
        end else begin
            pc          <= imem_addr;
            fetch_valid <= 1'b1;
        end
    end

    // --------------------
    // immediate decode
    always_comb begin
        case (inst.r_fmt.opcode)
            OPC_OP_IMM, OPC_LOAD:
                imm = {{20{inst.i_fmt.imm11_0[11]}}, inst.i_fmt.imm11_0};
            OPC_STORE:
                imm = {{20{inst.s_fmt.imm11_5[6]}}, inst.s_fmt.imm11_5, inst.s_fmt.imm4_0};
            OPC_BRANCH:
                imm = {{20{inst.b_fmt.imm12}}, inst.b_fmt.imm11, inst.b_fmt.imm10_5,
                       inst.b_fmt.imm4_1, 1'b0};
            OPC_LUI:
                imm = {inst.u_fmt.imm31_12, 12'b0};
            OPC_JAL:
                imm = {{12{inst.j_fmt.imm20}}, inst.j_fmt.imm19_12, inst.j_fmt.imm11,
                       inst.j_fmt.imm10_1, 1'b0};
            default:
                imm = '0;
        endcase
    end

    reg_file i_reg_file (
        .clk (clk),
        .ra1 (inst.r_fmt.rs1),
        .ra2 (inst.r_fmt.rs2),
        .rd1 (rs1_data),
        .rd2 (rs2_data),
        .we  (wb_we),
        .wa  (wb_rd),
        .wd  (wb_data)
    );

    // --------------------
    // fd -> ex register
    always_ff @(posedge clk) begin
        if (rst) begin
            fd.valid <= 1'b0;
        end else begin
            fd.valid <= !kill;
        end
    end

    always_ff @(posedge clk) begin
        fd.inst     <= kill ? NOP_INST : inst; // bubble after a redirect
        fd.pc       <= pc;
        fd.rs1_data <= rs1_data;
        fd.rs2_data <= rs2_data;
        fd.imm      <= imm;
    end

    // the word that became a valid instruction was fully defined
    a_fetch_known: assert property (@(posedge clk) disable iff (rst)
        fd.valid |-> !$isunknown($past(imem_data)));

endmodule

//--- execute/alu.sv
module alu import riscv_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic [2:0]      funct3,
    input  logic            alt,    // sub / arithmetic shift
    output logic [XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (funct3)
            F3_ADD_SUB: result = alt ? a - b : a + b;
            F3_SLL:     result = a << shamt;
            F3_SLT:     result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            F3_SLTU:    result = {{(XLEN-1){1'b0}}, a < b};
            F3_XOR:     result = a ^ b;
            F3_SRL_SRA: result = alt ? $unsigned($signed(a) >>> shamt) : a >> shamt;
            F3_OR:      result = a | b;
            F3_AND:     result = a & b;
            default:    result = '0;
        endcase
    end

endmodule

//--- execute/execute.sv
module execute import riscv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    fd_ex_if.ex                   fd,
    ex_wb_if.ex                   wb,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic                  wb_we,
    input  logic [XLEN-1:0]       wb_data,
    output logic                  redirect,
    output logic [XLEN-1:0]       redirect_pc,
    output logic                  ex_retire,
    output logic                  ex_cnt_reset
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            is_op;
    logic            is_op_imm;
    logic            is_lui;
    logic            is_branch;
    logic            is_jal;
    logic            is_load;
    logic            is_store;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] op_b;
    logic [2:0]      alu_f3;
    logic            alu_alt;
    logic [XLEN-1:0] alu_out;
    logic            br_cond;
    logic [1:0]      wb_sel;

    assign opcode    = fd.inst.r_fmt.opcode;
    assign funct3    = fd.inst.r_fmt.funct3;
    assign is_op     = opcode == OPC_OP;
    assign is_op_imm = opcode == OPC_OP_IMM;
    assign is_lui    = opcode == OPC_LUI;
    assign is_branch = opcode == OPC_BRANCH;
    assign is_jal    = opcode == OPC_JAL;
    assign is_load   = opcode == OPC_LOAD;
    assign is_store  = opcode == OPC_STORE;

    // --------------------
    // older results reach decode through the write-through regfile
    assign rs1 = (wb_we && wb_rd != '0 && wb_rd == fd.inst.r_fmt.rs1) ? wb_data : fd.rs1_data;
    assign rs2 = (wb_we && wb_rd != '0 && wb_rd == fd.inst.r_fmt.rs2) ? wb_data : fd.rs2_data;

    assign op_b    = is_op ? rs2 : fd.imm;
    assign alu_f3  = (is_op || is_op_imm) ? funct3 : F3_ADD_SUB; // loads/stores add
    assign alu_alt = fd.inst.r_fmt.funct7[5] && (is_op || (is_op_imm && funct3 == F3_SRL_SRA));

    alu i_alu (
        .a      (rs1),
        .b      (op_b),
        .funct3 (alu_f3),
        .alt    (alu_alt),
        .result (alu_out)
    );

    always_comb begin
        case (funct3)
            F3_BEQ:  br_cond = rs1 == rs2;
            F3_BNE:  br_cond = rs1 != rs2;
            F3_BLT:  br_cond = $signed(rs1) < $signed(rs2);
            F3_BGE:  br_cond = $signed(rs1) >= $signed(rs2);
            F3_BLTU: br_cond = rs1 < rs2;
            F3_BGEU: br_cond = rs1 >= rs2;
            default: br_cond = 1'b0;
        endcase
    end

    assign redirect     = fd.valid && (is_jal || (is_branch && br_cond));
    assign redirect_pc  = fd.pc + fd.imm;
    assign ex_retire    = fd.valid;
    assign ex_cnt_reset = fd.valid && is_store && alu_out == ADDR_CNT_RESET;

    always_comb begin
        if (is_jal)       wb_sel = WB_PC4;  // link value
        else if (is_load) wb_sel = WB_MMIO;
        else if (is_lui)  wb_sel = WB_IMM;
        else              wb_sel = WB_ALU;
    end

    // --------------------
    // ex -> wb register
    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid    <= 1'b0;
            wb.reg_we   <= 1'b0;
            wb.is_load  <= 1'b0;
            wb.is_store <= 1'b0;
        end else begin
            wb.valid    <= fd.valid;
            wb.reg_we   <= fd.valid && (is_op || is_op_imm || is_lui || is_jal || is_load);
            wb.is_load  <= fd.valid && is_load;
            wb.is_store <= fd.valid && is_store;
        end
    end

    always_ff @(posedge clk) begin
        wb.rd         <= fd.inst.r_fmt.rd;
        wb.wb_sel     <= wb_sel;
        wb.result     <= alu_out;
        wb.store_data <= rs2;
        wb.pc         <= fd.pc;
        wb.imm        <= fd.imm;
    end

    // the slot behind a taken branch or jal arrives flushed
    a_redirect_flush: assert property (@(posedge clk) disable iff (rst)
        redirect |=> !fd.valid);

endmodule

//--- writeback/writeback.sv
module writeback import riscv_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    ex_wb_if.wb                      wb,
    input  logic                     ex_retire,
    input  logic                     ex_cnt_reset,
    input  logic [SWITCH_W-1:0]      switches,
    output logic [LED_W-1:0]         leds,
    output logic [PMOD_W-1:0]        pmod_leds,
    output logic                     tone_enable,
    output logic [TONE_PERIOD_W-1:0] tone_period,
    output logic [REG_ADDR_W-1:0]    wb_rd,
    output logic                     wb_we,
    output logic [XLEN-1:0]          wb_data
);

    logic [XLEN-1:0] cycle_cnt;
    logic [XLEN-1:0] instr_cnt;
    logic [XLEN-1:0] load_data;
    logic            store;

    // --------------------
    // counters cleared by a store still in execute
    always_ff @(posedge clk) begin
        if (rst || ex_cnt_reset) begin
            cycle_cnt <= '0;
            instr_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (ex_retire) begin
                instr_cnt <= instr_cnt + 1'b1;
            end
        end
    end

    assign store = wb.valid && wb.is_store;

    // --------------------
    // peripheral registers
    always_ff @(posedge clk) begin
        if (rst) begin
            leds        <= '0;
            pmod_leds   <= '0;
            tone_enable <= 1'b0;
            tone_period <= TONE_PERIOD_RESET;
        end else if (store) begin
            case (wb.result)
                ADDR_LEDS: begin
                    leds      <= wb.store_data[LED_W-1:0];
                    pmod_leds <= wb.store_data[15:8];
                end
                ADDR_TONE_EN:     tone_enable <= wb.store_data[0];
                ADDR_TONE_PERIOD: tone_period <= wb.store_data[TONE_PERIOD_W-1:0];
                default:          ;
            endcase
        end
    end

    always_comb begin
        case (wb.result)
            ADDR_CYCLE_CNT: load_data = cycle_cnt;
            ADDR_INSTR_CNT: load_data = instr_cnt;
            ADDR_SWITCHES:  load_data = {{(XLEN-SWITCH_W){1'b0}}, switches};
            default:        load_data = '0; // unmapped reads as zero
        endcase
    end

    always_comb begin
        case (wb.wb_sel)
            WB_PC4:  wb_data = wb.pc + 32'd4;
            WB_ALU:  wb_data = wb.result;
            WB_MMIO: wb_data = load_data;
            default: wb_data = wb.imm;      // lui
        endcase
    end

    assign wb_rd = wb.rd;
    assign wb_we = wb.valid && wb.reg_we;

    // mmio accesses are whole words
    a_mmio_aligned: assert property (@(posedge clk) disable iff (rst)
        wb.valid && (wb.is_load || wb.is_store) |-> wb.result[1:0] == 2'b00);

endmodule

//--- src/core_top.sv
module core_top import riscv_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    output logic [XLEN-1:0]          imem_addr,
    input  logic [XLEN-1:0]          imem_data,
    input  logic [SWITCH_W-1:0]      switches,
    output logic [LED_W-1:0]         leds,
    output logic [PMOD_W-1:0]        pmod_leds,
    output logic                     tone_enable,
    output logic [TONE_PERIOD_W-1:0] tone_period
);

    logic                  redirect;
    logic [XLEN-1:0]       redirect_pc;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic                  wb_we;
    logic [XLEN-1:0]       wb_data;
    logic                  ex_retire;
    logic                  ex_cnt_reset;

    fd_ex_if fd_ex ();
    ex_wb_if ex_wb ();

    fetch_decode i_fetch_decode (
        .clk         (clk),
        .rst         (rst),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_rd       (wb_rd),
        .wb_we       (wb_we),
        .wb_data     (wb_data),
        .fd          (fd_ex.fd)
    );

    execute i_execute (
        .clk          (clk),
        .rst          (rst),
        .fd           (fd_ex.ex),
        .wb           (ex_wb.ex),
        .wb_rd        (wb_rd),
        .wb_we        (wb_we),
        .wb_data      (wb_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .ex_retire    (ex_retire),
        .ex_cnt_reset (ex_cnt_reset)
    );

    writeback i_writeback (
        .clk          (clk),
        .rst          (rst),
        .wb           (ex_wb.wb),
        .ex_retire    (ex_retire),
        .ex_cnt_reset (ex_cnt_reset),
        .switches     (switches),
        .leds         (leds),
        .pmod_leds    (pmod_leds),
        .tone_enable  (tone_enable),
        .tone_period  (tone_period),
        .wb_rd        (wb_rd),
        .wb_we        (wb_we),
        .wb_data      (wb_data)
    );

endmodule

//--- tb/tb_tasks.svh
// --------------------
// instruction encoders
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    inst_u w;
    w.r_fmt.funct7 = f7;
    w.r_fmt.rs2    = rs2;
    w.r_fmt.rs1    = rs1;
    w.r_fmt.funct3 = f3;
    w.r_fmt.rd     = rd;
    w.r_fmt.opcode = OPC_OP;
    return w;
endfunction

function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [11:0] imm,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    inst_u w;
    w.i_fmt.imm11_0 = imm;
    w.i_fmt.rs1     = rs1;
    w.i_fmt.funct3  = f3;
    w.i_fmt.rd      = rd;
    w.i_fmt.opcode  = opc;
    return w;
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    inst_u w;
    w.s_fmt.imm11_5 = imm[11:5];
    w.s_fmt.rs2     = rs2;
    w.s_fmt.rs1     = rs1;
    w.s_fmt.funct3  = 3'b010; // sw
    w.s_fmt.imm4_0  = imm[4:0];
    w.s_fmt.opcode  = OPC_STORE;
    return w;
endfunction

function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [12:0] imm);
    inst_u w;
    w.b_fmt.imm12   = imm[12];
    w.b_fmt.imm10_5 = imm[10:5];
    w.b_fmt.rs2     = rs2;
    w.b_fmt.rs1     = rs1;
    w.b_fmt.funct3  = f3;
    w.b_fmt.imm4_1  = imm[4:1];
    w.b_fmt.imm11   = imm[11];
    w.b_fmt.opcode  = OPC_BRANCH;
    return w;
endfunction

function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
    inst_u w;
    w.u_fmt.imm31_12 = imm;
    w.u_fmt.rd       = rd;
    w.u_fmt.opcode   = OPC_LUI;
    return w;
endfunction

function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] imm);
    inst_u w;
    w.j_fmt.imm20    = imm[20];
    w.j_fmt.imm10_1  = imm[10:1];
    w.j_fmt.imm11    = imm[11];
    w.j_fmt.imm19_12 = imm[19:12];
    w.j_fmt.rd       = rd;
    w.j_fmt.opcode   = OPC_JAL;
    return w;
endfunction

function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        F3_BEQ:  return a == b;
        F3_BNE:  return a != b;
        F3_BLT:  return $signed(a) < $signed(b);
        F3_BGE:  return $signed(a) >= $signed(b);
        F3_BLTU: return a < b;
        F3_BGEU: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// --------------------
// directed tests
task automatic check_reset_values();
    string name;
    name = "reset_values";
    start_program();
    end_program();
    reset_dut();
    @(negedge clk); // first cycle out of reset
    check_value(name, "imem_addr", RESET_PC, imem_addr);
    check_value(name, "leds", 32'd0, 32'(leds));
    check_value(name, "pmod_leds", 32'd0, 32'(pmod_leds));
    check_value(name, "tone_enable", 32'd0, 32'(tone_enable));
    check_value(name, "tone_period", 32'(TONE_PERIOD_RESET), 32'(tone_period));
endtask

task automatic alu_forwarding();
    string       name;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] lt;
    bit          done;
    name = "alu_chain";
    a = lfsr_bits(32);
    b = lfsr_bits(32);

    // reference model of the chain below
    r  = a + b;
    r  = a - r;
    r  = r ^ b;
    r  = r << a[4:0];
    r  = $signed(r) >>> b[4:0];
    lt = (r < a) ? 32'd1 : 32'd0;
    r  = (r & b) + lt;

    start_program();
    emit_word(lui_word(5'd31, 20'h80000)); // mmio base
    load_const(5'd1, a);
    load_const(5'd2, b);
    emit_word(r_type(7'h00, 5'd2, 5'd1, F3_ADD_SUB, 5'd3));
    emit_word(r_type(7'h20, 5'd3, 5'd1, F3_ADD_SUB, 5'd3)); // sub
    emit_word(r_type(7'h00, 5'd2, 5'd3, F3_XOR, 5'd3));
    emit_word(r_type(7'h00, 5'd1, 5'd3, F3_SLL, 5'd3));
    emit_word(r_type(7'h20, 5'd2, 5'd3, F3_SRL_SRA, 5'd3)); // sra
    emit_word(r_type(7'h00, 5'd1, 5'd3, F3_SLTU, 5'd4));
    emit_word(r_type(7'h00, 5'd2, 5'd3, F3_AND, 5'd3)); // x3 from two back
    emit_word(r_type(7'h00, 5'd4, 5'd3, F3_ADD_SUB, 5'd3));
    emit_word(s_type(ADDR_TONE_PERIOD[11:0], 5'd3, 5'd31));
    end_program();
    reset_dut();
    wait_tone_change(name, done);
    if (done) begin
        check_value(name, "tone_period", {8'd0, r[23:0]}, 32'(tone_period));
    end
endtask

task automatic branches_and_jal();
    string       name;
    logic [2:0]  kinds [6];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] va;
    logic [31:0] vb;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] acc;
    logic [31:0] link;
    bit          done;
    name  = "branches";
    kinds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    a     = lfsr_bits(32) | 32'h80000000; // negative, so signed and unsigned differ
    b     = lfsr_bits(32) & 32'h7fffffff;
    acc   = 32'd1;

    start_program();
    emit_word(lui_word(5'd31, 20'h80000));
    load_const(5'd1, a);
    load_const(5'd2, b);
    emit_word(i_type(OPC_OP_IMM, 12'd1, 5'd0, F3_ADD_SUB, 5'd10));
    for (int k = 0; k < 6; k++) begin
        // operand pairs (x1,x2) (x2,x1) (x1,x1)
        for (int p = 0; p < 3; p++) begin
            rs1 = (p == 1) ? 5'd2 : 5'd1;
            rs2 = (p == 0) ? 5'd2 : 5'd1;
            va  = (p == 1) ? b : a;
            vb  = (p == 0) ? b : a;
            emit_word(i_type(OPC_OP_IMM, 12'd1, 5'd10, F3_SLL, 5'd10));
            emit_word(b_type(kinds[k], rs1, rs2, 13'd8)); // skips the ori when taken
            emit_word(i_type(OPC_OP_IMM, 12'd1, 5'd10, F3_OR, 5'd10));
            acc = (acc << 1) | {31'd0, !branch_taken(kinds[k], va, vb)};
        end
    end
    link = prog_addr + 32'd4;
    emit_word(jal_word(5'd5, 21'd8));
    emit_word(i_type(OPC_OP_IMM, 12'd0, 5'd0, F3_ADD_SUB, 5'd5)); // must be skipped
    emit_word(s_type(ADDR_LEDS[11:0], 5'd5, 5'd31));
    emit_word(s_type(ADDR_TONE_PERIOD[11:0], 5'd10, 5'd31));
    end_program();
    reset_dut();
    wait_tone_change(name, done);
    if (done) begin
        check_value(name, "tone_period", {8'd0, acc[23:0]}, 32'(tone_period));
        check_value(name, "leds", {26'd0, link[5:0]}, 32'(leds));
        check_value(name, "pmod_leds", {24'd0, link[15:8]}, 32'(pmod_leds));
    end
endtask

task automatic switch_to_leds();
    string       name;
    logic [31:0] s;
    bit          done;
    name = "switches";
    s    = lfsr_bits(SWITCH_W);
    @(posedge clk);
    switches <= s[SWITCH_W-1:0];

    start_program();
    emit_word(lui_word(5'd31, 20'h80000));
    emit_word(i_type(OPC_LOAD, ADDR_SWITCHES[11:0], 5'd31, 3'b010, 5'd5));
    emit_word(i_type(OPC_OP_IMM, 12'd8, 5'd5, F3_SLL, 5'd6));
    emit_word(r_type(7'h00, 5'd5, 5'd6, F3_OR, 5'd6));
    emit_word(s_type(ADDR_LEDS[11:0], 5'd6, 5'd31));
    emit_word(i_type(OPC_OP_IMM, 12'd1, 5'd0, F3_ADD_SUB, 5'd7));
    emit_word(s_type(ADDR_TONE_PERIOD[11:0], 5'd7, 5'd31)); // done marker
    end_program();
    reset_dut();
    wait_tone_change(name, done);
    if (done) begin
        check_value(name, "pmod_leds", {24'd0, s[7:0]}, 32'(pmod_leds));
        check_value(name, "leds", {26'd0, s[5:0]}, 32'(leds));
    end
endtask

task automatic counter_reset();
    string       name;
    logic [31:0] addr;
    int          k;
    bit          done;
    for (int i = 0; i < 2; i++) begin
        name = (i == 0) ? "instr_count" : "cycle_count";
        addr = (i == 0) ? ADDR_INSTR_CNT : ADDR_CYCLE_CNT;
        k    = 3 + int'(lfsr_bits(3)); // 3 to 10
        start_program();
        emit_word(lui_word(5'd31, 20'h80000));
        emit_word(s_type(ADDR_CNT_RESET[11:0], 5'd0, 5'd31));
        repeat (k) emit_word(NOP_INST);
        emit_word(i_type(OPC_LOAD, addr[11:0], 5'd31, 3'b010, 5'd5));
        emit_word(s_type(ADDR_TONE_PERIOD[11:0], 5'd5, 5'd31));
        end_program();
        reset_dut();
        wait_tone_change(name, done);
        if (done) begin
            check_value(name, "tone_period", 32'(k + 1), 32'(tone_period));
        end
    end
endtask

//--- tb/tb_core.sv
module tb_core import riscv_pkg::*; ();

    localparam int WAIT_LIMIT = 200;

    logic                     clk = 1'b0;
    logic                     rst;
    logic [XLEN-1:0]          imem_addr;
    logic [XLEN-1:0]          imem_data;
    logic [SWITCH_W-1:0]      switches;
    logic [LED_W-1:0]         leds;
    logic [PMOD_W-1:0]        pmod_leds;
    logic                     tone_enable;
    logic [TONE_PERIOD_W-1:0] tone_period;

    logic [31:0] imem [logic [31:0]]; // sparse, keyed by byte address
    logic [31:0] prog_addr;
    logic [31:0] lfsr_state;
    int          checks;
    int          errors;
    int          timeouts;

    always #10 clk = ~clk;

    core_top i_core_top (
        .clk         (clk),
        .rst         (rst),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .switches    (switches),
        .leds        (leds),
        .pmod_leds   (pmod_leds),
        .tone_enable (tone_enable),
        .tone_period (tone_period)
    );

    // --------------------
    // instruction memory, one cycle read latency
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if ($isunknown(addr) || !imem.exists(addr)) begin
            return NOP_INST;
        end
        return imem[addr];
    endfunction

    always @(posedge clk) begin
        imem_data <= fetch_word(imem_addr);
    end

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    // --------------------
    // program building
    task automatic start_program();
        imem.delete();
        prog_addr = RESET_PC;
    endtask

    task automatic emit_word(input logic [31:0] word);
        imem[prog_addr] = word;
        prog_addr = prog_addr + 32'd4;
    endtask

    task automatic end_program();
        emit_word(jal_word(5'd0, 21'd0)); // spin here
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h800) >> 12; // addi sign-extends the low part
        emit_word(lui_word(rd, hi[19:0]));
        emit_word(i_type(OPC_OP_IMM, value[11:0], rd, F3_ADD_SUB, rd));
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic wait_tone_change(input string test_name, output bit done);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (tone_period === TONE_PERIOD_RESET && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        done = (tone_period !== TONE_PERIOD_RESET);
        assert (done) else begin
            $display("ERROR %s: tone_period did not change within %0d cycles",
                     test_name, WAIT_LIMIT);
            timeouts++;
        end
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAIL %s (%s): expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    `include "tb_tasks.svh"

    initial begin
        rst        = 1'b1;
        switches   = '0;
        imem_data  = NOP_INST;
        lfsr_state = 32'h9237e33c;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;

        check_reset_values();
        alu_forwarding();
        branches_and_jal();
        switch_to_leds();
        counter_reset();

        $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+tb
common/riscv_pkg.sv
common/stage_if.sv
fetch_decode/reg_file.sv
fetch_decode/fetch_decode.sv
execute/alu.sv
execute/execute.sv
writeback/writeback.sv
src/core_top.sv
tb/tb_core.sv
